/* source/fdc_pkg.sv */
package fdc_pkg;

	////////////////////////////////////////
	// Clocking

	localparam int clk_master_hz = 50_000_000;                  // Matches 20 ns period
	localparam int tick_10us_cycles = clk_master_hz / 100_000;  // Index reference tick
	localparam int tick_250us_cycles = clk_master_hz / 4_000;   // Step-rate tick

	// SRAM write FIFO
	localparam int fifo_depth = 16;
	localparam int fifo_ptr_w = $clog2(fifo_depth);

	// Firmware identity
	localparam logic [15:0] mco_type = 16'hDD55;
	localparam logic [15:0] mco_version = 16'h0023;

	////////////////////////////////////////
	// Widths with a meaning

	typedef logic [7:0] byte_t;          // MCU and SRAM data byte
	typedef logic [7:0] reg_addr_t;      // Register address
	typedef logic [18:0] sram_addr_t;    // 512 K address space
	typedef logic [15:0] index_count_t;  // Index period in 10 us units
	typedef logic [6:0] step_count_t;    // Steps still to go

	////////////////////////////////////////
	// Register map

	localparam reg_addr_t reg_addr_low = 8'h00;
	localparam reg_addr_t reg_addr_high = 8'h01;
	localparam reg_addr_t reg_addr_upper = 8'h02;
	localparam reg_addr_t reg_sram_data = 8'h03;
	localparam reg_addr_t reg_drive_ctl = 8'h04;  // Reads give type and version
	localparam reg_addr_t reg_status1 = 8'h0E;
	localparam reg_addr_t reg_status2 = 8'h0F;
	localparam reg_addr_t reg_scratch = 8'h30;    // 31 to 33 are read only
	localparam reg_addr_t reg_index_hi = 8'h40;
	localparam reg_addr_t reg_index_lo = 8'h41;
	localparam reg_addr_t reg_step_rate = 8'hF0;
	localparam reg_addr_t reg_step_cmd = 8'hFF;

	// State machines
	typedef enum logic [2:0] {mwc_idle, mwc_oe_off, mwc_write, mwc_write_end, mwc_inc_addr}
		mwc_state_t;
	typedef enum logic [1:0] {step_idle, step_pulse, step_settle} step_state_t;

endpackage

/* source/fdc_ifs.sv */
////////////////////////////////////////
// SRAM address and write path

interface sram_ctl_if import fdc_pkg::*; ();
	byte_t wr_byte;        // Byte from the MCU bus
	logic data_wr;         // Push wr_byte into the FIFO
	logic load_low;        // Address byte loads
	logic load_high;
	logic load_upper;
	logic rd_done;         // SRAM data read finished
	sram_addr_t addr;      // Current SRAM address
	logic addr_empty;      // Address is zero
	logic addr_full;       // Address is all ones
	logic fifo_busy;       // Write path still has data

	modport host (
		output wr_byte, data_wr, load_low, load_high, load_upper, rd_done,
		input addr, addr_empty, addr_full, fifo_busy
	);
	modport mem (
		input wr_byte, data_wr, load_low, load_high, load_upper, rd_done,
		output addr, addr_empty, addr_full, fifo_busy
	);
endinterface

////////////////////////////////////////
// Head stepper control

interface stepper_if import fdc_pkg::*; ();
	byte_t step_rate;   // Step clock divider
	byte_t cmd_byte;    // Direction in bit 7, count below
	logic cmd_wr;
	logic stepping;
	logic track0_hit;   // Seek ran into track 0

	modport host (output step_rate, cmd_byte, cmd_wr, input stepping, track0_hit);
	modport stepper (input step_rate, cmd_byte, cmd_wr, output stepping, track0_hit);
endinterface

////////////////////////////////////////
// Index period readout

interface index_if import fdc_pkg::*; ();
	logic hi_read;      // High byte read starting
	byte_t period_hi;
	byte_t period_lo;
	logic new_meas;

	modport host (output hi_read, input period_hi, period_lo, new_meas);
	modport timer (input hi_read, output period_hi, period_lo, new_meas);
endinterface

/* source/mcu_regs.sv */
module mcu_regs import fdc_pkg::*; (
	input logic CLK_MASTER,
	input logic reset,
	input logic mcu_pmall,
	input logic mcu_pmrd,
	input logic mcu_pmwr,
	input byte_t mcu_pmd_in,
	input byte_t sram_rd_data,
	input logic [4:0] drive_in,       // index, track0, wrprot, rdy, dens
	output byte_t mcu_pmd_out,
	output byte_t drive_ctl,
	sram_ctl_if.host sram,
	stepper_if.host step,
	index_if.host index
);

	reg_addr_t addr_lat;               // Register address from the bus
	logic [1:0] strb_s0, strb_s1, strb_s2;  // Bit 1 is PMWR, bit 0 is PMRD
	logic rd_pulse, rd_fall, wr_pulse;
	logic rd_busy;
	byte_t wr_data;
	byte_t scratch;
	byte_t step_rate_r;
	byte_t sram_rd_lat;

	////////////////////////////////////////
	// Address latch and strobe sync

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			addr_lat <= '0;
			strb_s0 <= '0;
			strb_s1 <= '0;
			strb_s2 <= '0;
		end else begin
			if (mcu_pmall)
				addr_lat <= mcu_pmd_in;  // Follows the bus while ALE is high
			strb_s0 <= {mcu_pmwr, mcu_pmrd};
			strb_s1 <= strb_s0;
			strb_s2 <= strb_s1;          // Edge detect stage
		end
	end

	assign rd_pulse = strb_s1[0] & ~strb_s2[0];
	assign rd_fall = ~strb_s1[0] & strb_s2[0];
	assign wr_pulse = strb_s1[1] & ~strb_s2[1];
	assign rd_busy = strb_s1[0] && (addr_lat == reg_sram_data);

	////////////////////////////////////////
	// Write decode

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			drive_ctl <= '0;
			scratch <= '0;
			step_rate_r <= '0;
			sram.data_wr <= 1'b0;
			sram.load_low <= 1'b0;
			sram.load_high <= 1'b0;
			sram.load_upper <= 1'b0;
			sram.rd_done <= 1'b0;
			step.cmd_wr <= 1'b0;
		end else begin
			// One-cycle pulses, aligned with wr_data
			sram.data_wr <= wr_pulse && (addr_lat == reg_sram_data);
			sram.load_low <= wr_pulse && (addr_lat == reg_addr_low);
			sram.load_high <= wr_pulse && (addr_lat == reg_addr_high);
			sram.load_upper <= wr_pulse && (addr_lat == reg_addr_upper);
			step.cmd_wr <= wr_pulse && (addr_lat == reg_step_cmd);
			sram.rd_done <= rd_fall && (addr_lat == reg_sram_data);  // Advance after read
			if (wr_pulse) begin
				case (addr_lat)
					reg_drive_ctl: drive_ctl <= mcu_pmd_in;
					reg_scratch: scratch <= mcu_pmd_in;
					reg_step_rate: step_rate_r <= mcu_pmd_in;
					default: ;
				endcase
			end
		end
	end

	// Payload bytes
	always_ff @(posedge CLK_MASTER) begin
		if (wr_pulse)
			wr_data <= mcu_pmd_in;
		if (!rd_busy)
			sram_rd_lat <= sram_rd_data;  // Hold SRAM byte steady for the host
	end

	assign sram.wr_byte = wr_data;
	assign step.cmd_byte = wr_data;
	assign step.step_rate = step_rate_r;
	assign index.hi_read = rd_pulse && (addr_lat == reg_index_hi);

	////////////////////////////////////////
	// Readback

	always_comb begin
		case (addr_lat)
			reg_addr_low: mcu_pmd_out = sram.addr[7:0];
			reg_addr_high: mcu_pmd_out = sram.addr[15:8];
			reg_addr_upper: mcu_pmd_out = {5'b0, sram.addr[18:16]};
			reg_sram_data: mcu_pmd_out = sram_rd_lat;
			reg_drive_ctl: mcu_pmd_out = mco_type[7:0];  // Type low byte
			reg_drive_ctl + 8'd1: mcu_pmd_out = mco_type[15:8];
			reg_drive_ctl + 8'd2: mcu_pmd_out = mco_version[7:0];
			reg_drive_ctl + 8'd3: mcu_pmd_out = mco_version[15:8];
			reg_status1: mcu_pmd_out = {3'b0, step.track0_hit, index.new_meas, 2'b0,
				sram.fifo_busy};
			reg_status2: mcu_pmd_out = {drive_in, step.stepping, sram.addr_empty,
				sram.addr_full};
			reg_scratch: mcu_pmd_out = scratch;
			reg_scratch + 8'd1: mcu_pmd_out = ~scratch;  // Inverse for bus tests
			reg_scratch + 8'd2: mcu_pmd_out = 8'h55;
			reg_scratch + 8'd3: mcu_pmd_out = 8'hAA;
			reg_index_hi: mcu_pmd_out = index.period_hi;
			reg_index_lo: mcu_pmd_out = index.period_lo;
			default: mcu_pmd_out = 8'h00;
		endcase
	end

	// A write push and a read advance come from strobes that never overlap
	a_no_wr_rd_overlap: assert property (@(posedge CLK_MASTER) disable iff (reset)
		!(sram.data_wr && sram.rd_done))
		else $error("FIFO push and SRAM read advance in the same cycle");

endmodule

/* source/sram_writer.sv */
module sram_writer import fdc_pkg::*; (
	input logic CLK_MASTER,
	input logic reset,
	output logic sram_we_n,
	output logic sram_oe_n,
	output byte_t fifo_q,      // Byte on its way to the SRAM
	output logic addr_inc,
	sram_ctl_if.mem sram
);

	byte_t fifo_mem [fifo_depth];
	logic [fifo_ptr_w:0] wr_ptr, rd_ptr;  // Extra bit tells full from empty
	logic fifo_empty, fifo_full;
	mwc_state_t state;

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_full = (wr_ptr[fifo_ptr_w] != rd_ptr[fifo_ptr_w]) &&
		(wr_ptr[fifo_ptr_w-1:0] == rd_ptr[fifo_ptr_w-1:0]);
	assign sram.fifo_busy = !fifo_empty || (state != mwc_idle) || addr_inc;

	////////////////////////////////////////
	// FIFO storage

	always_ff @(posedge CLK_MASTER) begin
		if (sram.data_wr && !fifo_full)
			fifo_mem[wr_ptr[fifo_ptr_w-1:0]] <= sram.wr_byte;
		if (state == mwc_oe_off)
			fifo_q <= fifo_mem[rd_ptr[fifo_ptr_w-1:0]];  // Pop into output register
	end

	////////////////////////////////////////
	// Write sequencer

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			state <= mwc_idle;
			wr_ptr <= '0;
			rd_ptr <= '0;
			sram_we_n <= 1'b1;
			sram_oe_n <= 1'b0;
			addr_inc <= 1'b0;
		end else begin
			if (sram.data_wr && !fifo_full)
				wr_ptr <= wr_ptr + 1'b1;
			case (state)
				mwc_idle: begin
					sram_we_n <= 1'b1;
					sram_oe_n <= 1'b0;  // SRAM drives the bus for reads
					addr_inc <= 1'b0;
					if (!fifo_empty)
						state <= mwc_oe_off;
				end
				mwc_oe_off: begin
					sram_oe_n <= 1'b1;  // Release bus before we drive it
					rd_ptr <= rd_ptr + 1'b1;
					state <= mwc_write;
				end
				mwc_write: begin
					sram_we_n <= 1'b0;  // Single cycle write strobe
					state <= mwc_write_end;
				end
				mwc_write_end: begin
					sram_we_n <= 1'b1;
					state <= mwc_inc_addr;
				end
				mwc_inc_addr: begin
					addr_inc <= 1'b1;   // Address moves after WE is high
					state <= mwc_idle;
				end
				default: state <= mwc_idle;
			endcase
		end
	end

	// Host strobe spacing keeps the FIFO from overflowing
	a_no_push_full: assert property (@(posedge CLK_MASTER) disable iff (reset)
		sram.data_wr |-> !fifo_full) else $error("Push into full SRAM write FIFO");
	a_we_oe_excl: assert property (@(posedge CLK_MASTER) disable iff (reset)
		!(!sram_we_n && !sram_oe_n)) else $error("SRAM WE and OE low together");

endmodule

/* source/sram_addr_counter.sv */
module sram_addr_counter import fdc_pkg::*; (
	input logic CLK_MASTER,
	input logic reset,
	input logic addr_inc,     // From the write sequencer
	sram_ctl_if.mem sram
);

	sram_addr_t addr;

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			addr <= '0;
		end else if (sram.load_low) begin
			addr[7:0] <= sram.wr_byte;
		end else if (sram.load_high) begin
			addr[15:8] <= sram.wr_byte;
		end else if (sram.load_upper) begin
			addr[18:16] <= sram.wr_byte[2:0];  // Only 512 K
		end else if (addr_inc || sram.rd_done) begin
			addr <= addr + 1'b1;              // Wraps at the top
		end
	end

	assign sram.addr = addr;
	assign sram.addr_empty = (addr == '0);
	assign sram.addr_full = &addr;

endmodule

/* source/index_timer.sv */
module index_timer import fdc_pkg::*; (
	input logic CLK_MASTER,
	input logic reset,
	input logic fd_index_in,
	index_if.timer index
);

	logic [15:0] tick_cnt;
	logic tick;                 // 10 us reference
	logic [2:0] idx_s;          // Sync plus edge stage
	logic idx_rise;
	index_count_t period_cnt;
	index_count_t period_lat;   // Last full measurement

	assign tick = (tick_cnt == 16'(tick_10us_cycles - 1));
	assign idx_rise = idx_s[1] & ~idx_s[2];

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			tick_cnt <= '0;
			idx_s <= '0;
			period_cnt <= '0;
			period_lat <= '0;
			index.period_lo <= '0;
			index.new_meas <= 1'b0;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			idx_s <= {idx_s[1:0], fd_index_in};
			if (idx_rise) begin
				period_lat <= period_cnt;  // Save and restart
				period_cnt <= '0;
			end else if (tick && (period_cnt != '1)) begin
				period_cnt <= period_cnt + 1'b1;  // Saturates with no index
			end
			if (index.hi_read)
				index.period_lo <= period_lat[7:0];  // Pairs with the high byte shown
			if (index.hi_read)
				index.new_meas <= 1'b0;  // Clear beats a new edge
			else if (idx_rise)
				index.new_meas <= 1'b1;
		end
	end

	assign index.period_hi = period_lat[15:8];

endmodule

/* source/head_stepper.sv */
module head_stepper import fdc_pkg::*; (
	input logic CLK_MASTER,
	input logic reset,
	input logic fd_track0_in,
	stepper_if.stepper step,
	output logic fd_step,      // Active low step pulse
	output logic fd_dir        // High steps inward
);

	logic [15:0] tick_cnt;
	logic tick;                // 250 us
	byte_t rate_cnt;
	logic step_clk;
	logic step_rise, step_fall;
	logic [1:0] trk0_s;
	step_count_t steps_left;
	step_state_t state;

	assign tick = (tick_cnt == 16'(tick_250us_cycles - 1));
	// Step clock edges, one cycle ahead of the toggle
	assign step_rise = tick && (rate_cnt == step.step_rate) && !step_clk;
	assign step_fall = tick && (rate_cnt == step.step_rate) && step_clk;
	assign step.stepping = (state != step_idle);

	////////////////////////////////////////
	// Step clock divider

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			tick_cnt <= '0;
			rate_cnt <= '0;
			step_clk <= 1'b0;
			trk0_s <= '0;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			trk0_s <= {trk0_s[0], fd_track0_in};
			if (tick) begin
				if (rate_cnt == step.step_rate) begin
					rate_cnt <= '0;
					step_clk <= ~step_clk;  // Half period is step_rate + 1 ticks
				end else begin
					rate_cnt <= rate_cnt + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////
	// Step command FSM

	always_ff @(posedge CLK_MASTER) begin
		if (reset) begin
			state <= step_idle;
			steps_left <= '0;
			fd_step <= 1'b1;
			fd_dir <= 1'b0;
			step.track0_hit <= 1'b0;
		end else begin
			case (state)
				step_idle: if (step.cmd_wr) begin
					fd_dir <= step.cmd_byte[7];
					steps_left <= step.cmd_byte[6:0];
					step.track0_hit <= 1'b0;
					state <= step_settle;
				end
				step_settle: begin
					if (steps_left == '0) begin
						state <= step_idle;
					end else if (!fd_dir && trk0_s[1]) begin
						steps_left <= '0;           // Outward seek hit the stop
						step.track0_hit <= 1'b1;
						state <= step_idle;
					end else if (step_rise) begin
						fd_step <= 1'b0;
						steps_left <= steps_left - 1'b1;
						state <= step_pulse;
					end
				end
				step_pulse: if (step_fall) begin
					fd_step <= 1'b1;  // Pulse lasts one half period
					state <= step_settle;
				end
				default: state <= step_idle;
			endcase
		end
	end

	// The host waits for the busy flag before a new seek
	a_cmd_when_idle: assert property (@(posedge CLK_MASTER) disable iff (reset)
		step.cmd_wr |-> !step.stepping) else $error("Step command while stepping");

endmodule

/* source/fdc_top.sv */
module fdc_top import fdc_pkg::*; (
	input logic CLK_MASTER,
	input logic reset,
	// MCU bus
	inout wire [7:0] mcu_pmd,
	input logic mcu_pmall,
	input logic mcu_pmrd,
	input logic mcu_pmwr,
	// SRAM
	output logic [18:0] sram_a,
	inout wire [7:0] sram_dq,
	output logic sram_we_n,
	output logic sram_oe_n,
	output logic sram_ce_n,
	// Drive outputs, active low
	output logic fd_dens_out,
	output logic fd_inuse,
	output logic [3:0] fd_drvsel,
	output logic fd_moten,
	output logic fd_sidesel,
	output logic fd_dir,
	output logic fd_step,
	// Drive inputs
	input logic fd_index_in,
	input logic fd_track0_in,
	input logic fd_wrprot_in,
	input logic fd_rdy_dchg_in,
	input logic fd_dens_in,
	output logic status_led
);

	byte_t pmd_out, drive_ctl, fifo_q;
	logic addr_inc;

	sram_ctl_if sram_bus ();
	stepper_if step_bus ();
	index_if index_bus ();

	mcu_regs u_regs (.CLK_MASTER, .reset, .mcu_pmall, .mcu_pmrd, .mcu_pmwr,
		.mcu_pmd_in(mcu_pmd), .sram_rd_data(sram_dq),
		.drive_in({fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_dchg_in, fd_dens_in}),
		.mcu_pmd_out(pmd_out), .drive_ctl, .sram(sram_bus.host), .step(step_bus.host),
		.index(index_bus.host));
	sram_writer u_writer (.CLK_MASTER, .reset, .sram_we_n, .sram_oe_n, .fifo_q, .addr_inc,
		.sram(sram_bus.mem));
	sram_addr_counter u_addr (.CLK_MASTER, .reset, .addr_inc, .sram(sram_bus.mem));
	index_timer u_index (.CLK_MASTER, .reset, .fd_index_in, .index(index_bus.timer));
	head_stepper u_step (.CLK_MASTER, .reset, .fd_track0_in, .step(step_bus.stepper),
		.fd_step, .fd_dir);

	// Tri-state buses
	assign mcu_pmd = mcu_pmrd ? pmd_out : 8'hzz;   // Host reading
	assign sram_dq = sram_oe_n ? fifo_q : 8'hzz;   // Writing when SRAM outputs are off
	assign sram_a = sram_bus.addr;
	assign sram_ce_n = 1'b0;                       // Always selected

	// Drive control bits, inverted for the open collector drivers
	assign fd_dens_out = ~drive_ctl[0];
	assign fd_inuse = ~drive_ctl[1];
	assign fd_drvsel = ~drive_ctl[5:2];
	assign fd_moten = ~drive_ctl[6];
	assign fd_sidesel = ~drive_ctl[7];
	assign status_led = ~sram_bus.fifo_busy;       // LED sinks current while busy

endmodule

/* test/sram_model.sv */
module sram_model import fdc_pkg::*; (
	input sram_addr_t sram_a,
	inout wire [7:0] sram_dq,
	input logic sram_we_n,
	input logic sram_oe_n,
	input logic sram_ce_n
);
	timeunit 1ns;
	timeprecision 1ps;

	byte_t mem [2**19];   // 512 K x 8

	// Fill pattern folds in every address bit
	initial begin
		for (int i = 0; i < 2**19; i++)
			mem[i] = byte_t'(i ^ (i >> 8) ^ (i >> 16));
	end

	////////////////////////////////////////
	// Read and write ports

	assign sram_dq = (!sram_ce_n && !sram_oe_n && sram_we_n) ? mem[sram_a] : 8'hzz;

	// Address and data settle a cycle before WE falls
	always @(negedge sram_we_n) begin
		if (!sram_ce_n)
			mem[sram_a] = sram_dq;
	end

endmodule

/* test/tb_fdc.sv */
module tb_fdc import fdc_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	// Index test about 100 k cycles, stepping about 90 k, rest a few thousand
	localparam int timeout_cycles = 400_000;

	logic CLK_MASTER;
	logic reset;
	logic mcu_pmall, mcu_pmrd, mcu_pmwr;
	logic pmd_oe;                     // Testbench drives the MCU bus
	byte_t pmd_drv;
	wire [7:0] mcu_pmd;
	sram_addr_t sram_a;
	wire [7:0] sram_dq;
	logic sram_we_n, sram_oe_n, sram_ce_n;
	logic fd_dens_out, fd_inuse, fd_moten, fd_sidesel, fd_dir, fd_step;
	logic [3:0] fd_drvsel;
	logic fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_dchg_in, fd_dens_in;
	logic status_led;
	int cycle_count = 0;
	int step_pulses = 0;              // Falling edges of fd_step
	int inward_pulses = 0;            // Same, with fd_dir high
	logic [31:0] rng_state = 32'hda40_5725;
	string test_name;

	assign mcu_pmd = pmd_oe ? pmd_drv : 8'hzz;

	fdc_top dut0 (.*);
	sram_model sram0 (.sram_a, .sram_dq, .sram_we_n, .sram_oe_n, .sram_ce_n);

	always #10 CLK_MASTER = ~CLK_MASTER;  // 50 MHz

	always @(posedge CLK_MASTER) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			abort_run($sformatf("Timeout after %0d cycles, a test is stuck", cycle_count));
	end

	always @(negedge fd_step) begin
		step_pulses <= step_pulses + 1;
		if (fd_dir)
			inward_pulses <= inward_pulses + 1;
	end

	////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic byte_t random_byte();
		rng_state = xorshift32(rng_state);
		return rng_state[7:0];
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_value(input string what, input byte_t expected, input byte_t actual);
		if (actual !== expected)
			abort_run($sformatf("[FAIL] %s, %s: expected %02h, actual %02h", test_name, what,
				expected, actual));
	endtask

	////////////////////////////////////////
	// MCU bus cycles, entered on a falling edge

	task automatic latch_address(input reg_addr_t addr);
		pmd_drv = addr;
		pmd_oe = 1'b1;
		mcu_pmall = 1'b1;
		repeat (4) @(negedge CLK_MASTER);
		mcu_pmall = 1'b0;
	endtask

	task automatic mcu_write(input reg_addr_t addr, input byte_t data);
		latch_address(addr);
		pmd_drv = data;
		mcu_pmwr = 1'b1;
		repeat (4) @(negedge CLK_MASTER);
		mcu_pmwr = 1'b0;
		repeat (4) @(negedge CLK_MASTER);  // Data held through the idle gap
		pmd_oe = 1'b0;
	endtask

	task automatic mcu_read(input reg_addr_t addr, output byte_t data);
		latch_address(addr);
		pmd_oe = 1'b0;                     // Hand the bus to the DUT
		mcu_pmrd = 1'b1;
		repeat (4) @(negedge CLK_MASTER);
		data = mcu_pmd;                    // Valid two cycles after PMRD rises
		mcu_pmrd = 1'b0;
		repeat (4) @(negedge CLK_MASTER);
	endtask

	task automatic load_sram_address(input sram_addr_t a);
		mcu_write(reg_addr_low, a[7:0]);
		mcu_write(reg_addr_high, a[15:8]);
		mcu_write(reg_addr_upper, {5'b0, a[18:16]});
	endtask

	// Re-read a status register until the masked bits match
	task automatic poll_status(input reg_addr_t addr, input byte_t mask, input byte_t want,
		input int max_polls, input string what);
		byte_t d;
		int polls;
		polls = 0;
		mcu_read(addr, d);
		while ((d & mask) !== want) begin
			if (polls == max_polls)
				abort_run({what, " did not finish within the polling limit"});
			polls++;
			repeat (50) @(negedge CLK_MASTER);
			mcu_read(addr, d);
		end
	endtask

	task automatic pulse_index(output int rise_cycle);
		fd_index_in = 1'b1;
		rise_cycle = cycle_count;
		repeat (20) @(negedge CLK_MASTER);
		fd_index_in = 1'b0;
	endtask

	////////////////////////////////////////
	// Directed tests

	task automatic reset_state_check();
		byte_t d;
		test_name = "reset state";
		check_value("SRAM CE, WE and OE", 8'h02, {5'b0, sram_ce_n, sram_we_n, sram_oe_n});
		check_value("step and direction", 8'h02, {6'b0, fd_step, fd_dir});
		check_value("drive outputs", 8'hFF,
			{fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens_out});
		check_value("status LED off", 8'h01, {7'b0, status_led});  // FIFO empty
		mcu_read(reg_status1, d);
		check_value("STATUS1", 8'h00, d);
		mcu_read(reg_status2, d);
		check_value("STATUS2", 8'h02, d);  // Not stepping, address zero
	endtask

	task automatic identity_and_scratch();
		byte_t d, value, inv;
		test_name = "identity and scratchpad";
		mcu_read(reg_drive_ctl, d);
		check_value("type low", 8'h55, d);
		mcu_read(8'h05, d);
		check_value("type high", 8'hDD, d);
		mcu_read(8'h06, d);
		check_value("version low", 8'h23, d);
		mcu_read(8'h07, d);
		check_value("version high", 8'h00, d);
		value = random_byte();
		inv = ~value;
		mcu_write(reg_scratch, value);
		mcu_read(reg_scratch, d);
		check_value("scratchpad", value, d);
		mcu_read(8'h31, d);
		check_value("inverse scratchpad", inv, d);
		mcu_read(8'h32, d);
		check_value("pattern 55", 8'h55, d);
		mcu_read(8'h33, d);
		check_value("pattern AA", 8'hAA, d);
	endtask

	task automatic drive_control();
		byte_t d, value, expected;
		test_name = "drive control";
		value = random_byte();
		expected = ~value;                 // Drive lines are active low
		mcu_write(reg_drive_ctl, value);
		check_value("drive outputs", expected,
			{fd_sidesel, fd_moten, fd_drvsel, fd_inuse, fd_dens_out});
		value = random_byte();
		{fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_dchg_in, fd_dens_in} = value[4:0];
		expected = {value[4:0], 3'b010};   // Not stepping, address still zero
		mcu_read(reg_status2, d);
		check_value("STATUS2 drive inputs", expected, d);
		{fd_index_in, fd_track0_in, fd_wrprot_in, fd_rdy_dchg_in, fd_dens_in} = 5'b0;
	endtask

	task automatic sram_write_read();
		byte_t stored [8];
		byte_t d;
		sram_addr_t a;
		test_name = "SRAM write and read";
		load_sram_address(19'h00010);
		for (int i = 0; i < 8; i++) begin
			stored[i] = random_byte();
			mcu_write(reg_sram_data, stored[i]);
		end
		check_value("status LED lit", 8'h00, {7'b0, status_led});  // Last byte in flight
		poll_status(reg_status1, 8'h01, 8'h00, 100, "FIFO drain");
		check_value("status LED off after drain", 8'h01, {7'b0, status_led});
		mcu_read(reg_addr_low, d);
		check_value("address low", 8'h18, d);
		mcu_read(reg_addr_high, d);
		check_value("address high", 8'h00, d);
		mcu_read(reg_addr_upper, d);
		check_value("address upper", 8'h00, d);
		for (int i = 0; i < 8; i++) begin
			a = 19'h10 + 19'(i);
			check_value("SRAM content", stored[i], sram0.mem[a]);
		end
		load_sram_address(19'h00010);
		for (int i = 0; i < 8; i++) begin
			mcu_read(reg_sram_data, d);  // Address steps after each read
			check_value("SRAM readback", stored[i], d);
		end
	endtask

	task automatic address_flags();
		byte_t d;
		test_name = "address flags";
		load_sram_address('0);
		mcu_read(reg_status2, d);
		check_value("empty flag at zero", 8'h02, d & 8'h03);
		load_sram_address('1);
		mcu_read(reg_status2, d);
		check_value("full flag at top", 8'h01, d & 8'h03);
		mcu_read(reg_sram_data, d);      // Wraps to zero
		mcu_read(reg_addr_low, d);
		check_value("wrapped low", 8'h00, d);
		mcu_read(reg_addr_high, d);
		check_value("wrapped high", 8'h00, d);
		mcu_read(reg_addr_upper, d);
		check_value("wrapped upper", 8'h00, d);
		mcu_read(reg_status2, d);
		check_value("empty flag after wrap", 8'h02, d & 8'h03);
	endtask

	task automatic index_period();
		byte_t d, hi, lo;
		int rise_cycle;
		test_name = "index period";
		pulse_index(rise_cycle);
		mcu_read(reg_index_hi, d);       // Drops any older measurement flag
		mcu_read(reg_status1, d);
		check_value("flag after high read", 8'h00, d & 8'h08);
		while (cycle_count < rise_cycle + 100_000)  // 2 ms
			@(negedge CLK_MASTER);
		pulse_index(rise_cycle);
		mcu_read(reg_status1, d);
		check_value("flag after edge", 8'h08, d & 8'h08);
		mcu_read(reg_index_hi, hi);
		mcu_read(reg_index_lo, lo);
		mcu_read(reg_status1, d);
		check_value("flag after readout", 8'h00, d & 8'h08);
		check_value("period high byte", 8'h00, hi);
		// 200 ticks of 10 us, one tick of phase slop
		if (lo < 8'd199 || lo > 8'd201)
			abort_run($sformatf("[FAIL] %s, period low byte: expected 200 +/- 1, actual %0d",
				test_name, lo));
	endtask

	task automatic head_stepping();
		byte_t d, n;
		int pulses0, inward0;
		test_name = "head stepping";
		mcu_write(reg_step_rate, 8'h00);
		pulses0 = step_pulses;
		inward0 = inward_pulses;
		mcu_write(reg_step_cmd, 8'h83);  // Inward, 3 steps
		poll_status(reg_status2, 8'h04, 8'h00, 3000, "Inward seek");
		check_value("step pulses", 8'd3, byte_t'(step_pulses - pulses0));
		check_value("inward pulses", 8'd3, byte_t'(inward_pulses - inward0));
		fd_track0_in = 1'b1;
		pulses0 = step_pulses;
		mcu_write(reg_step_cmd, 8'h64);  // Outward, 100 steps
		poll_status(reg_status2, 8'h04, 8'h00, 3000, "Outward seek to track 0");
		n = byte_t'(step_pulses - pulses0);
		if (n > 8'd1)
			abort_run($sformatf("[FAIL] %s, pulses at track 0: expected at most 1, actual %0d",
				test_name, n));
		mcu_read(reg_status1, d);
		check_value("track 0 flag", 8'h10, d & 8'h10);
		fd_track0_in = 1'b0;
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		CLK_MASTER = 1'b0;
		reset = 1'b1;
		mcu_pmall = 1'b0;
		mcu_pmrd = 1'b0;
		mcu_pmwr = 1'b0;
		pmd_oe = 1'b0;
		pmd_drv = '0;
		fd_index_in = 1'b0;
		fd_track0_in = 1'b0;
		fd_wrprot_in = 1'b0;
		fd_rdy_dchg_in = 1'b0;
		fd_dens_in = 1'b0;
		repeat (2) @(negedge CLK_MASTER);
		reset = 1'b0;
		@(negedge CLK_MASTER);
		reset_state_check();
		identity_and_scratch();
		drive_control();
		sram_write_read();
		address_flags();
		index_period();
		head_stepping();
		$display(">>> PASS");
		$finish;
	end

endmodule

/* project.f */
source/fdc_pkg.sv
source/fdc_ifs.sv
source/mcu_regs.sv
source/sram_writer.sv
source/sram_addr_counter.sv
source/index_timer.sv
source/head_stepper.sv
source/fdc_top.sv
test/sram_model.sv
test/tb_fdc.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_fdc
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "No result found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
